/* hdl/mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// Primary opcodes of the supported subset.
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JR} pc_action_t;
	typedef enum logic [1:0] {RD1_RS, RD1_RT, RD1_NONE} rd1_src_t;
	typedef enum logic [1:0] {RD2_RS, RD2_RT, RD2_NONE} rd2_src_t;
	typedef enum logic [1:0] {WA_RD, WA_RT, WA_R31} wr_addr_src_t;
	typedef enum logic [1:0] {WD_ALU, WD_MEM, WD_PC4} wr_data_src_t;
	typedef enum logic {IMM_SIGNED, IMM_UNSIGNED} imm_ext_t;
	typedef enum logic [1:0] {B_REG, B_IMM, B_SHAMT} alu_b_src_t;

	typedef struct packed {
		rd1_src_t     rd1_src;
		rd2_src_t     rd2_src;
		wr_addr_src_t wr_addr_src;
		wr_data_src_t wr_data_src;
		logic         reg_we;
		imm_ext_t     imm_ext;
		alu_b_src_t   alu_b_src;
		alu_op_t      alu_op;
		logic         mem_we;
		pc_action_t   pc_action;
		logic         branch_on_equal; // Else branch on not equal.
	} ctrl_t;

	// One retired instruction.
	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     instr;
		logic      reg_we;
		reg_addr_t reg_addr;
		word_t     reg_data;
		logic      mem_we;
		word_t     mem_addr;
		word_t     mem_data;
	} retire_t;

endpackage

/* hdl/mips_decode.sv */
`timescale 1ns/10ps

module mips_decode (
	input  mips_pkg::word_t instr,
	output mips_pkg::ctrl_t ctrl
);

	localparam mips_pkg::ctrl_t NOP_CTRL = '{
		rd1_src:         mips_pkg::RD1_NONE,
		rd2_src:         mips_pkg::RD2_NONE,
		wr_addr_src:     mips_pkg::WA_RD,
		wr_data_src:     mips_pkg::WD_ALU,
		reg_we:          1'b0,
		imm_ext:         mips_pkg::IMM_SIGNED,
		alu_b_src:       mips_pkg::B_REG,
		alu_op:          mips_pkg::ALU_ADD,
		mem_we:          1'b0,
		pc_action:       mips_pkg::PC_SEQ,
		branch_on_equal: 1'b0
	};

	mips_pkg::opcode_t op;
	mips_pkg::funct_t fn;

	assign op = mips_pkg::opcode_t'(instr[31:26]);
	assign fn = mips_pkg::funct_t'(instr[5:0]);

	always_comb begin
		ctrl = NOP_CTRL;
		case (op)
			mips_pkg::OP_SPECIAL: begin
				ctrl.rd1_src = mips_pkg::RD1_RS;
				ctrl.rd2_src = mips_pkg::RD2_RT;
				ctrl.reg_we = 1'b1;
				case (fn)
					mips_pkg::F_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::F_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::F_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::F_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::F_NOR:  ctrl.alu_op = mips_pkg::ALU_NOR;
					mips_pkg::F_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::F_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::F_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
					mips_pkg::F_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
					mips_pkg::F_SRA:  ctrl.alu_op = mips_pkg::ALU_SRA;
					mips_pkg::F_JR: begin
						ctrl.rd2_src = mips_pkg::RD2_NONE;
						ctrl.reg_we = 1'b0;
						ctrl.pc_action = mips_pkg::PC_JR;
					end
					default: ctrl = NOP_CTRL;
				endcase
				// Shifts read rt on port 1, amount comes from shamt.
				if (ctrl.alu_op inside {mips_pkg::ALU_SLL, mips_pkg::ALU_SRL, mips_pkg::ALU_SRA}) begin
					ctrl.rd1_src = mips_pkg::RD1_RT;
					ctrl.rd2_src = mips_pkg::RD2_NONE;
					ctrl.alu_b_src = mips_pkg::B_SHAMT;
				end
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
			mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_LW: begin
				ctrl.rd1_src = mips_pkg::RD1_RS;
				ctrl.wr_addr_src = mips_pkg::WA_RT;
				ctrl.reg_we = 1'b1;
				ctrl.alu_b_src = mips_pkg::B_IMM;
				if (op inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI})
					ctrl.imm_ext = mips_pkg::IMM_UNSIGNED; // Logic ops zero extend.
				case (op)
					mips_pkg::OP_SLTI: ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:  ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI: ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::OP_LUI:  ctrl.alu_op = mips_pkg::ALU_LUI;
					mips_pkg::OP_LW:   ctrl.wr_data_src = mips_pkg::WD_MEM;
					default:           ctrl.alu_op = mips_pkg::ALU_ADD;
				endcase
			end
			mips_pkg::OP_SW: begin
				ctrl.rd1_src = mips_pkg::RD1_RS;
				ctrl.rd2_src = mips_pkg::RD2_RT;
				ctrl.alu_b_src = mips_pkg::B_IMM;
				ctrl.mem_we = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				ctrl.rd1_src = mips_pkg::RD1_RS;
				ctrl.rd2_src = mips_pkg::RD2_RT;
				ctrl.alu_op = mips_pkg::ALU_SUB; // Zero flag compares.
				ctrl.pc_action = mips_pkg::PC_BRANCH;
				ctrl.branch_on_equal = (op == mips_pkg::OP_BEQ);
			end
			mips_pkg::OP_J: ctrl.pc_action = mips_pkg::PC_JUMP;
			mips_pkg::OP_JAL: begin
				ctrl.pc_action = mips_pkg::PC_JUMP;
				ctrl.wr_addr_src = mips_pkg::WA_R31;
				ctrl.wr_data_src = mips_pkg::WD_PC4;
				ctrl.reg_we = 1'b1;
			end
			default: ctrl = NOP_CTRL; // Unknown opcode runs as a no-op.
		endcase
	end

	always_comb
		assert ($isunknown(instr) || !$isunknown(ctrl)) else $error("decode: unknown control bits");

endmodule

/* hdl/mips_regfile.sv */
`timescale 1ns/10ps

module mips_regfile (
	input  logic                clock,
	input  logic                rst_n,
	input  mips_pkg::reg_addr_t rd1_addr,
	input  mips_pkg::reg_addr_t rd2_addr,
	output mips_pkg::word_t     rd1_data,
	output mips_pkg::word_t     rd2_data,
	input  logic                we,
	input  mips_pkg::reg_addr_t wr_addr,
	input  mips_pkg::word_t     wr_data
);

	mips_pkg::word_t regs [0:31];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data; // r0 never written.
		end
	end

	assign rd1_data = regs[rd1_addr];
	assign rd2_data = regs[rd2_addr];

	// r0 stays zero from reset on, whatever the core writes.
	assert property (@(posedge clock) disable iff (!rst_n)
		rd1_addr == 5'd0 |-> rd1_data == '0)
		else $error("regfile: r0 reads nonzero");

endmodule

/* hdl/mips_alu.sv */
`timescale 1ns/10ps

module mips_alu (
	input  mips_pkg::alu_op_t op,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	output mips_pkg::word_t   result,
	output logic              zero
);

	logic [4:0] shamt;

	assign shamt = a[4:0]; // Shift amount rides on a.

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD:  result = a + b;
			mips_pkg::ALU_SUB:  result = a - b;
			mips_pkg::ALU_AND:  result = a & b;
			mips_pkg::ALU_OR:   result = a | b;
			mips_pkg::ALU_XOR:  result = a ^ b;
			mips_pkg::ALU_NOR:  result = ~(a | b);
			mips_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			mips_pkg::ALU_SLTU: result = {31'b0, a < b};
			mips_pkg::ALU_SLL:  result = b << shamt;
			mips_pkg::ALU_SRL:  result = b >> shamt;
			mips_pkg::ALU_SRA:  result = $signed(b) >>> shamt;
			mips_pkg::ALU_LUI:  result = {b[15:0], 16'b0};
			default:            result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* hdl/mips_pc.sv */
`timescale 1ns/10ps

module mips_pc (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 run,
	input  mips_pkg::pc_action_t action,
	input  logic                 branch_on_equal,
	input  logic                 zero,
	input  mips_pkg::word_t      offset,
	input  logic [25:0]          target,
	input  mips_pkg::word_t      reg_target,
	output mips_pkg::word_t      pc,
	output mips_pkg::word_t      pc_plus4
);

	mips_pkg::word_t pc_next;
	logic taken;

	assign pc_plus4 = pc + 32'd4;
	assign taken = (zero == branch_on_equal);

	always_comb begin
		case (action)
			mips_pkg::PC_BRANCH: pc_next = taken ? pc_plus4 + offset : pc_plus4;
			mips_pkg::PC_JUMP:   pc_next = {pc_plus4[31:28], target, 2'b00};
			mips_pkg::PC_JR:     pc_next = reg_target;
			default:             pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n || !run)
			pc <= '0; // Stopped core restarts at 0.
		else
			pc <= pc_next;
	end

	// Catches a jr to a misaligned register value.
	assert property (@(posedge clock) disable iff (!rst_n)
		pc[1:0] == 2'b00)
		else $error("pc: misaligned address %h", pc);

endmodule

/* hdl/mips_mem.sv */
`timescale 1ns/10ps

module mips_mem #(
	parameter int ADDR_W = 6
) (
	input  logic              clock,
	input  logic              we,
	input  logic [ADDR_W-1:0] addr,
	input  mips_pkg::word_t   wdata,
	output mips_pkg::word_t   rdata
);

	localparam int DEPTH = 1 << ADDR_W;

	mips_pkg::word_t mem [0:DEPTH-1];

	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= wdata;
	end

	assign rdata = mem[addr]; // Read in the same cycle.

	// An X on we would corrupt an unknown set of words.
	assert property (@(posedge clock) !$isunknown(we))
		else $error("mem: write enable unknown");

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/10ps

module mips_core #(
	parameter int IMEM_W = 6,
	parameter int DMEM_W = 8
) (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                run,
	input  logic                prog_we,
	input  logic [IMEM_W-1:0]   prog_addr,
	input  mips_pkg::word_t     prog_data,
	output mips_pkg::retire_t   retire
);

	mips_pkg::word_t instr, pc, pc_plus4;
	mips_pkg::ctrl_t ctrl;
	mips_pkg::reg_addr_t rd1_addr, rd2_addr, wr_addr;
	mips_pkg::word_t rd1_data, rd2_data, wr_data;
	mips_pkg::word_t imm_word, offset, alu_a, alu_b, alu_result, dmem_rdata;
	logic [IMEM_W-1:0] imem_addr;
	logic alu_zero, active, reg_we, mem_we;

	assign active = run & rst_n;
	assign reg_we = ctrl.reg_we & active;
	assign mem_we = ctrl.mem_we & active;

	// Program port takes the address while loading.
	assign imem_addr = prog_we ? prog_addr : pc[IMEM_W+1:2];

	mips_mem #(.ADDR_W(IMEM_W)) u_imem (
		.clock(clock), .we(prog_we), .addr(imem_addr), .wdata(prog_data), .rdata(instr)
	);

	mips_decode u_decode (.instr(instr), .ctrl(ctrl));

	always_comb begin
		case (ctrl.rd1_src)
			mips_pkg::RD1_RS: rd1_addr = instr[25:21];
			mips_pkg::RD1_RT: rd1_addr = instr[20:16];
			default:          rd1_addr = 5'd0;
		endcase
		case (ctrl.rd2_src)
			mips_pkg::RD2_RS: rd2_addr = instr[25:21];
			mips_pkg::RD2_RT: rd2_addr = instr[20:16];
			default:          rd2_addr = 5'd0;
		endcase
		case (ctrl.wr_addr_src)
			mips_pkg::WA_RT:  wr_addr = instr[20:16];
			mips_pkg::WA_R31: wr_addr = 5'd31; // jal link register.
			default:          wr_addr = instr[15:11];
		endcase
		case (ctrl.wr_data_src)
			mips_pkg::WD_MEM: wr_data = dmem_rdata;
			mips_pkg::WD_PC4: wr_data = pc_plus4;
			default:          wr_data = alu_result;
		endcase
	end

	mips_regfile u_regfile (
		.clock(clock), .rst_n(rst_n),
		.rd1_addr(rd1_addr), .rd2_addr(rd2_addr),
		.rd1_data(rd1_data), .rd2_data(rd2_data),
		.we(reg_we), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	assign imm_word = (ctrl.imm_ext == mips_pkg::IMM_UNSIGNED) ?
		{16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign offset = {imm_word[29:0], 2'b00}; // Branch offset in bytes.

	// Shifts put shamt on a and the rt value on b.
	always_comb begin
		alu_a = rd1_data;
		case (ctrl.alu_b_src)
			mips_pkg::B_IMM: alu_b = imm_word;
			mips_pkg::B_SHAMT: begin
				alu_a = {27'b0, instr[10:6]};
				alu_b = rd1_data;
			end
			default: alu_b = rd2_data;
		endcase
	end

	mips_alu u_alu (
		.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .zero(alu_zero)
	);

	mips_mem #(.ADDR_W(DMEM_W)) u_dmem (
		.clock(clock), .we(mem_we), .addr(alu_result[DMEM_W+1:2]),
		.wdata(rd2_data), .rdata(dmem_rdata)
	);

	mips_pc u_pc (
		.clock(clock), .rst_n(rst_n), .run(run),
		.action(ctrl.pc_action), .branch_on_equal(ctrl.branch_on_equal), .zero(alu_zero),
		.offset(offset), .target(instr[25:0]), .reg_target(rd1_data),
		.pc(pc), .pc_plus4(pc_plus4)
	);

	assign retire = '{
		valid:    active,
		pc:       pc,
		instr:    instr,
		reg_we:   reg_we,
		reg_addr: wr_addr,
		reg_data: wr_data,
		mem_we:   mem_we,
		mem_addr: alu_result,
		mem_data: rd2_data
	};

endmodule

/* bench/mips_clock_gen.sv */
`timescale 1ns/10ps

module mips_clock_gen (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period.
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1; // Released between edges.
	end

endmodule

/* bench/mips_iss.svh */
`ifndef MIPS_ISS_SVH
`define MIPS_ISS_SVH

// Model state, kept across rounds like the DUT.
mips_pkg::word_t iss_regs [0:31];
mips_pkg::word_t iss_dmem [0:255];
mips_pkg::word_t iss_pc;
mips_pkg::word_t program_words [0:63];
bit landable [0:63]; // Cleared where a jr sits.

localparam logic [65:0] R_FUNCTS = {6'h00, 6'h02, 6'h03, 6'h21, 6'h23, 6'h24,
	6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
localparam logic [35:0] I_OPS = {6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

function automatic int slot_addr(input int k);
	return (k * 31 + 5) * 4; // Data words stored by every program prefix.
endfunction

// Forward target that never lands on a jr.
function automatic int pick_target(input int p);
	int t;
	t = p + 1 + int'($urandom_range(0, 7));
	if (t > 63 || !landable[t])
		t = p + 1;
	return t;
endfunction

function automatic mips_pkg::word_t random_word(input int p);
	logic [4:0] rs, rt, rd;
	logic [5:0] fn, op;
	mips_pkg::word_t w;
	rs = 5'($urandom_range(0, 31));
	rt = 5'($urandom_range(0, 30));
	rd = 5'($urandom_range(0, 30)); // r31 only written by jal.
	fn = R_FUNCTS[6 * $urandom_range(0, 10) +: 6];
	op = I_OPS[6 * $urandom_range(0, 5) +: 6];
	case ($urandom_range(0, 11))
		0, 1, 2, 3: w = {6'h00, rs, rt, rd, 5'($urandom), fn};
		4, 5: w = {op, rs, rt, 16'($urandom)};
		6: w = {6'h23, 5'd0, rt, 16'(slot_addr(int'($urandom_range(0, 7))))}; // lw
		7: w = {6'h2b, 5'd0, rs, 16'($urandom_range(0, 255) * 4)}; // sw
		8, 9: w = {5'b00010, 1'($urandom), rs, rt, 16'(pick_target(p) - p - 1)};
		10: w = {6'h02, 26'(pick_target(p))};
		default: w = {6'h3f, 26'($urandom)}; // Unknown opcode.
	endcase
	return w;
endfunction

// Built from the end so that every target is already known.
task automatic gen_program();
	int p;
	int k;
	for (p = 0; p < 64; p++)
		landable[p] = 1'b1;
	program_words[63] = {6'h02, 26'd63}; // Parks on itself.
	p = 62;
	while (p >= 8) begin
		if (p >= 10 && $urandom_range(0, 9) == 0) begin
			// jal to a jr, which returns to a j past the block.
			program_words[p] = {6'h00, 5'd31, 15'd0, 6'h08};
			program_words[p - 1] = {6'h02, 26'(pick_target(p))};
			program_words[p - 2] = {6'h03, 26'(p)};
			landable[p] = 1'b0;
			p -= 3;
		end else begin
			program_words[p] = random_word(p);
			p--;
		end
	end
	for (k = 0; k < 8; k++)
		program_words[k] = {6'h2b, 5'd0, 5'($urandom_range(0, 31)), 16'(slot_addr(k))};
endtask

task automatic step_model(output mips_pkg::retire_t exp);
	mips_pkg::word_t ins, rs, rt, simm, res, next_pc;
	ins = program_words[iss_pc[7:2]];
	rs = iss_regs[ins[25:21]];
	rt = iss_regs[ins[20:16]];
	simm = {{16{ins[15]}}, ins[15:0]};
	res = '0;
	next_pc = iss_pc + 32'd4;
	exp = '0;
	exp.valid = 1'b1;
	exp.pc = iss_pc;
	exp.instr = ins;
	exp.reg_we = 1'b1; // Cleared below where nothing is written.
	exp.reg_addr = ins[20:16];
	case (ins[31:26])
		6'h00: begin
			exp.reg_addr = ins[15:11];
			case (ins[5:0])
				6'h00: res = rt << ins[10:6];
				6'h02: res = rt >> ins[10:6];
				6'h03: res = $signed(rt) >>> ins[10:6];
				6'h21: res = rs + rt;
				6'h23: res = rs - rt;
				6'h24: res = rs & rt;
				6'h25: res = rs | rt;
				6'h26: res = rs ^ rt;
				6'h27: res = ~(rs | rt);
				6'h2a: res = {31'b0, $signed(rs) < $signed(rt)};
				6'h2b: res = {31'b0, rs < rt};
				6'h08: begin
					exp.reg_we = 1'b0;
					next_pc = rs; // jr
				end
				default: exp.reg_we = 1'b0;
			endcase
		end
		6'h09: res = rs + simm;
		6'h0a: res = {31'b0, $signed(rs) < $signed(simm)};
		6'h0c: res = rs & {16'h0, ins[15:0]};
		6'h0d: res = rs | {16'h0, ins[15:0]};
		6'h0e: res = rs ^ {16'h0, ins[15:0]};
		6'h0f: res = {ins[15:0], 16'h0};
		6'h23: res = iss_dmem[8'((rs + simm) >> 2)];
		6'h2b: begin
			exp.reg_we = 1'b0;
			exp.mem_we = 1'b1;
			exp.mem_addr = rs + simm;
			exp.mem_data = rt;
			iss_dmem[8'((rs + simm) >> 2)] = rt;
		end
		6'h04, 6'h05: begin
			exp.reg_we = 1'b0;
			if ((rs == rt) == !ins[26])
				next_pc = next_pc + (simm << 2);
		end
		6'h02, 6'h03: begin
			exp.reg_we = ins[26]; // Only jal links.
			exp.reg_addr = 5'd31;
			res = iss_pc + 32'd4;
			next_pc = {next_pc[31:28], ins[25:0], 2'b00};
		end
		default: exp.reg_we = 1'b0;
	endcase
	exp.reg_data = res;
	if (exp.reg_we && exp.reg_addr != 5'd0)
		iss_regs[exp.reg_addr] = res;
	iss_pc = next_pc;
endtask

`endif

/* bench/mips_core_tb.sv */
`timescale 1ns/10ps

module mips_core_tb;

	localparam int ROUNDS = 4;
	localparam int RUN_CYCLES = 160;
	localparam int MAX_CYCLES = 2000; // About twice reset, loading and running.

	logic clock, rst_n, run, prog_we;
	logic [5:0] prog_addr;
	mips_pkg::word_t prog_data;
	mips_pkg::retire_t retire;
	int cycles = 0;

	mips_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

	mips_core #(.IMEM_W(6), .DMEM_W(8)) DUT (
		.clock(clock), .rst_n(rst_n), .run(run), .prog_we(prog_we),
		.prog_addr(prog_addr), .prog_data(prog_data), .retire(retire)
	);

	`include "mips_iss.svh"

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input mips_pkg::word_t got,
		input mips_pkg::word_t exp);
		abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_pc(input mips_pkg::retire_t got, input mips_pkg::retire_t exp);
		if (got.pc !== exp.pc)
			report_mismatch("retire.pc", got.pc, exp.pc);
		if (got.instr !== exp.instr)
			report_mismatch("retire.instr", got.instr, exp.instr);
	endtask

	task automatic check_reg_write(input mips_pkg::retire_t got, input mips_pkg::retire_t exp);
		if (got.reg_we !== exp.reg_we)
			report_mismatch("retire.reg_we", 32'(got.reg_we), 32'(exp.reg_we));
		if (exp.reg_we) begin
			if (got.reg_addr !== exp.reg_addr)
				report_mismatch("retire.reg_addr", 32'(got.reg_addr), 32'(exp.reg_addr));
			if (got.reg_data !== exp.reg_data)
				report_mismatch("retire.reg_data", got.reg_data, exp.reg_data);
		end
	endtask

	task automatic check_mem_write(input mips_pkg::retire_t got, input mips_pkg::retire_t exp);
		if (got.mem_we !== exp.mem_we)
			report_mismatch("retire.mem_we", 32'(got.mem_we), 32'(exp.mem_we));
		if (exp.mem_we) begin
			if (got.mem_addr !== exp.mem_addr)
				report_mismatch("retire.mem_addr", got.mem_addr, exp.mem_addr);
			if (got.mem_data !== exp.mem_data)
				report_mismatch("retire.mem_data", got.mem_data, exp.mem_data);
		end
	endtask

	task automatic confirm_stopped();
		if (retire.valid !== 1'b0)
			abort_run("a retire was valid while run was low");
	endtask

	task automatic load_program();
		int a;
		for (a = 0; a < 64; a++) begin
			@(negedge clock);
			prog_we = 1'b1;
			prog_addr = 6'(a);
			prog_data = program_words[a];
			#1;
			confirm_stopped();
		end
		@(negedge clock);
		prog_we = 1'b0;
	endtask

	// One retire per cycle, sampled after the falling edge drive settles.
	task automatic run_program(input int n);
		mips_pkg::retire_t exp;
		int c;
		for (c = 0; c < n; c++) begin
			@(negedge clock);
			run = 1'b1;
			#1;
			if (retire.valid !== 1'b1)
				abort_run("no valid retire in a cycle with run high");
			step_model(exp);
			check_pc(retire, exp);
			check_reg_write(retire, exp);
			check_mem_write(retire, exp);
		end
	endtask

	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			abort_run("timeout: the run passed its cycle limit");
	end

	initial begin
		int i;
		int round;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		void'($urandom(32'hbb19));
		for (i = 0; i < 32; i++)
			iss_regs[i] = '0;
		wait (rst_n === 1'b1);
		for (round = 0; round < ROUNDS; round++) begin
			@(negedge clock);
			run = 1'b0;
			#1;
			confirm_stopped();
			gen_program();
			load_program();
			iss_pc = '0; // PC restarts at 0 once run rises.
			run_program(RUN_CYCLES);
		end
		@(negedge clock);
		run = 1'b0;
		$display("All tests passed");
		$finish;
	end

endmodule

/* mips_core.f */
+incdir+bench
hdl/mips_pkg.sv
hdl/mips_decode.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_pc.sv
hdl/mips_mem.sv
hdl/mips_core.sv
bench/mips_clock_gen.sv
bench/mips_core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module mips_core_tb -f mips_core.f -Mdir obj_dir
	./obj_dir/Vmips_core_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
